//--- sources.f
hdl/cpuPkg.sv
hdl/decodeCtrlIf.sv
hdl/regReadIf.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/operandSelect.sv
hdl/branchControl.sv
hdl/decodeStage.sv
tests/decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench, fail unless the pass line appears
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/100ps \
       -f sources.f --top-module decodeStageTb -o simDecode \
  && out="$(./obj_dir/simDecode)" \
  && echo "$out" \
  && echo "$out" | grep -qx "sim passed" \
  || { echo "simulation did not pass"; exit 1; }

//--- tests/decodeStageTb.sv
`timescale 1ns/100ps

module decodeStageTb import cpuPkg::*; ();

  localparam int clkPeriod  = 40;
  localparam int watchdogNs = (16 + 700) * clkPeriod; // Reset plus a bound on all tests

  logic clk = 1'b0;
  logic reset;
  logic [15:0] inst, pcNext, wbData, branchTarget;
  flags_t flags;
  logic [3:0] wbRegRd;
  logic wbRegWrite, isBranch, taken;
  exBundle_t exSignals;
  memBundle_t memSignals;
  wbBundle_t wbSignals;

  logic [15:0] model [16];  // Register contents after the last rising edge
  int seed = 32'he969;
  int checks = 0, errors = 0, tests = 0, checksMark = 0, errorsMark = 0;
  logic [31:0] rnd, rnd2;
  logic [15:0] instWord, exp1, exp2, offs;
  logic [3:0] rs, rt, wrReg;
  logic wrEn;
  opcode_t op;
  opcode_t immOps [7] = '{SLL, SRA, ROR, LLB, LHB, LW, SW};

  always #(clkPeriod / 2) clk = ~clk;

  decodeStage decodeStage_inst (
    .clk (clk), .reset (reset), .inst (inst), .pcNext (pcNext), .flags (flags),
    .wbRegRd (wbRegRd), .wbRegWrite (wbRegWrite), .wbData (wbData),
    .exSignals (exSignals), .memSignals (memSignals), .wbSignals (wbSignals),
    .isBranch (isBranch), .branchTarget (branchTarget), .taken (taken)
  );

  //////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////
  function automatic logic [31:0] nextRand();
    return $random(seed);
  endfunction

  // Expected read data, zero register first, then the write of this cycle
  function automatic logic [15:0] readModel(input logic [3:0] r);
    if (r == 4'd0) return 16'h0000;
    if (wbRegWrite && r == wbRegRd) return wbData;
    return model[r];
  endfunction

  // {aluOp, zEn, nvEn, memEnable, memWrite, regWrite, memToReg, hlt, pcs}
  function automatic logic [15:0] expectCtrl(input opcode_t o);
    logic [3:0] aluOp;
    aluOp = (o <= PADDSB || o inside {LLB, LHB}) ? o : ADD;
    return {4'h0, aluOp, o inside {ADD, SUB, XOR, SLL, SRA, ROR}, o inside {ADD, SUB},
            o inside {LW, SW}, o == SW, o <= LW || o inside {LLB, LHB, PCS},
            o == LW, o == HLT, o == PCS};
  endfunction

  // Branch condition table
  function automatic logic condHolds(input logic [2:0] c, input flags_t f);
    case (c)
      3'd0: return !f.z;              // NE
      3'd1: return f.z;               // EQ
      3'd2: return !f.z && !f.n;      // GT
      3'd3: return f.n;               // LT
      3'd4: return f.z || !f.n;       // GE
      3'd5: return f.n || f.z;        // LE
      3'd6: return f.v;               // OV
      default: return 1'b1;           // UNC
    endcase
  endfunction

  task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Drive on the falling edge, return just before the next rising edge
  task automatic applyCycle(input logic [15:0] i, input logic [15:0] pc, input flags_t f,
                            input logic we, input logic [3:0] wr, input logic [15:0] wd);
    if (wbRegWrite && wbRegRd != 4'd0) model[wbRegRd] = wbData; // Commits at coming edge
    @(negedge clk);
    inst = i;
    pcNext = pc;
    flags = f;
    wbRegWrite = we;
    wbRegRd = wr;
    wbData = wd;
    #(clkPeriod / 2 - 5);
  endtask

  task automatic reportTest(input string name);
    tests++;
    $display("test %0d %s: %0d checks, %0d errors", tests, name,
             checks - checksMark, errors - errorsMark);
    checksMark = checks;
    errorsMark = errors;
  endtask

  //////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////
  initial begin
    reset = 1'b1;
    inst = 16'h0;
    pcNext = 16'h0;
    flags = 3'b000;
    wbRegRd = 4'd0;
    wbRegWrite = 1'b0;
    wbData = 16'h0;
    foreach (model[k]) model[k] = 16'h0000;
    for (int i = 0; i < 15; i++) begin // Writes under reset must not land
      @(negedge clk);
      rnd = nextRand();
      wbRegWrite = 1'b1;
      wbRegRd = rnd[19:16];
      wbData = rnd[15:0];
    end
    @(negedge clk);
    reset = 1'b0;
    wbRegWrite = 1'b0;
    wbRegRd = 4'd0;
    wbData = 16'h0;

    for (int i = 0; i < 20; i++) begin // Cleared registers read zero
      rnd = nextRand();
      applyCycle({ADD, rnd[11:0]}, 16'h0, 3'b000, 1'b0, 4'd0, 16'h0);
      checkVal("exSignals.aluIn1", exSignals.aluIn1, 16'h0000);
      checkVal("exSignals.aluIn2", exSignals.aluIn2, 16'h0000);
    end
    reportTest("reset state");

    for (int i = 0; i < 120; i++) begin // Writes, reads and bypass
      rnd = nextRand();
      rnd2 = nextRand();
      wrReg = rnd[19:16];
      wrEn = rnd[20];
      rs = (rnd2[1:0] == 2'd0) ? wrReg : rnd2[7:4];  // Often hit the write in flight
      rt = (rnd2[3:2] == 2'd0) ? wrReg : rnd2[11:8];
      applyCycle({ADD, rnd2[15:12], rs, rt}, 16'h0, 3'b000, wrEn, wrReg, rnd[15:0]);
      checkVal("exSignals.aluIn1", exSignals.aluIn1, readModel(rs));
      checkVal("exSignals.aluIn2", exSignals.aluIn2, readModel(rt));
    end
    reportTest("register reads");

    for (int i = 0; i < 16; i++) begin
      rnd = nextRand();
      op = opcode_t'(i[3:0]);
      applyCycle({op, rnd[11:0]}, 16'h0, 3'b000, 1'b0, 4'd0, 16'h0);
      checkVal("control bits", {4'h0, exSignals.aluOp, exSignals.zEn, exSignals.nvEn,
               memSignals.memEnable, memSignals.memWrite, wbSignals.regWrite,
               wbSignals.memToReg, wbSignals.hlt, wbSignals.pcs}, expectCtrl(op));
      checkVal("wbSignals.regRd", {12'h0, wbSignals.regRd}, {12'h0, rnd[11:8]});
    end
    reportTest("control table");

    for (int i = 0; i < 40; i++) begin // Immediate forms
      rnd = nextRand();
      op = immOps[rnd[18:16] % 3'd7];
      instWord = {op, rnd[11:0]};
      applyCycle(instWord, 16'h0, 3'b000, 1'b0, 4'd0, 16'h0);
      if (op inside {LW, SW}) exp2 = {{12{instWord[3]}}, instWord[3:0]};
      else if (op inside {LLB, LHB}) exp2 = {8'h00, instWord[7:0]};
      else exp2 = {12'h000, instWord[3:0]};
      exp1 = readModel(op inside {LLB, LHB} ? instWord[11:8] : instWord[7:4]);
      checkVal("exSignals.aluIn1", exSignals.aluIn1, exp1);
      checkVal("exSignals.aluIn2", exSignals.aluIn2, exp2);
      if (op == SW) begin
        checkVal("memSignals.memWriteData", memSignals.memWriteData,
                 readModel(instWord[11:8]));
      end
    end
    reportTest("immediates");

    for (int i = 0; i < 100; i++) begin // B and BR
      rnd = nextRand();
      rnd2 = nextRand();
      instWord = {(rnd[20:19] == 2'd0) ? BR : B, rnd[11:0]};
      applyCycle(instWord, rnd2[15:0], rnd2[18:16], 1'b0, 4'd0, 16'h0);
      offs = {{7{instWord[8]}}, instWord[8:0]};
      offs = offs << 1;
      exp1 = (instWord[15:12] == BR) ? readModel(instWord[7:4]) : rnd2[15:0] + offs;
      checkVal("isBranch", {15'h0, isBranch}, 16'h0001);
      checkVal("taken", {15'h0, taken}, {15'h0, condHolds(instWord[11:9], rnd2[18:16])});
      checkVal("branchTarget", branchTarget, exp1);
    end
    reportTest("branches");

    for (int i = 0; i < 16; i++) begin // Everything else never branches
      rnd = nextRand();
      op = opcode_t'(i[3:0]);
      if (!(op inside {B, BR})) begin
        applyCycle({op, rnd[11:0]}, rnd[31:16], rnd[14:12], 1'b0, 4'd0, 16'h0);
        checkVal("isBranch", {15'h0, isBranch}, 16'h0000);
        checkVal("taken", {15'h0, taken}, 16'h0000);
        checkVal("branchTarget", branchTarget, rnd[31:16]);
      end
    end
    reportTest("non-branches");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdogNs);
    $display("timeout: the tests did not finish within %0d ns", watchdogNs);
    $display("sim failed");
    $finish;
  end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  reset,        // Clears the register file
  input  logic [wordWidth-1:0]  inst,         // Instruction from fetch
  input  logic [wordWidth-1:0]  pcNext,       // Address after inst
  input  flags_t                flags,        // Flag register
  input  logic [regIdWidth-1:0] wbRegRd,      // Write-back destination
  input  logic                  wbRegWrite,   // Write-back strobe
  input  logic [wordWidth-1:0]  wbData,       // Write-back data
  output exBundle_t             exSignals,
  output memBundle_t            memSignals,
  output wbBundle_t             wbSignals,
  output logic                  isBranch,
  output logic [wordWidth-1:0]  branchTarget,
  output logic                  taken         // Branch condition holds
);

  decodeCtrlIf ctrlBus ();  // Decoder to consumers
  regReadIf    readBus ();  // Operand selector to register file

  ////////////////////////////////////////////////////////////
  // Decoder and register file side by side
  ////////////////////////////////////////////////////////////
  controlUnit iControl (
    .opcode (opcode_t'(inst[15:12])),
    .ctrl   (ctrlBus.source)
  );

  registerFile iRegFile (
    .clk        (clk),
    .reset      (reset),
    .rd         (readBus.responder),
    .wbRegRd    (wbRegRd),
    .wbRegWrite (wbRegWrite),
    .wbData     (wbData)
  );

  ////////////////////////////////////////////////////////////
  // Operands, bundles and branch resolution
  ////////////////////////////////////////////////////////////
  operandSelect iOperands (
    .inst (inst),
    .ctrl (ctrlBus.sink),
    .rd   (readBus.requester),
    .ex   (exSignals),
    .mem  (memSignals),
    .wb   (wbSignals)
  );

  branchControl iBranch (
    .inst     (inst),
    .branch   (ctrlBus.branchSink),
    .flags    (flags),
    .rsData   (readBus.srcData1), // rs read on port 1 for BR
    .pcNext   (pcNext),
    .isBranch (isBranch),
    .taken    (taken),
    .target   (branchTarget)
  );

endmodule

`default_nettype wire

//--- hdl/branchControl.sv
`timescale 1ns/100ps
`default_nettype none

module branchControl import cpuPkg::*; (
  input  logic [wordWidth-1:0] inst,     // Instruction word
  decodeCtrlIf.branchSink      branch,   // Branch line from decoder
  input  flags_t               flags,    // Z, V, N
  input  logic [wordWidth-1:0] rsData,   // BR target register
  input  logic [wordWidth-1:0] pcNext,   // Fall-through address
  output logic                 isBranch,
  output logic                 taken,
  output logic [wordWidth-1:0] target
);

  opcode_t              opcode;
  cond_t                cond;         // inst[11:9]
  logic                 condMet;
  logic [wordWidth-1:0] branchOffset; // 9-bit word offset as bytes

  assign opcode       = opcode_t'(inst[15:12]);
  assign cond         = cond_t'(inst[11:9]);
  assign branchOffset = {{(wordWidth-10){inst[8]}}, inst[8:0], 1'b0};

  ////////////////////////////////////////////////////////////
  // Condition check
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (cond)
      NE:      condMet = !flags.z;
      EQ:      condMet = flags.z;
      GT:      condMet = !flags.z && !flags.n;
      LT:      condMet = flags.n;
      GE:      condMet = flags.z || (!flags.z && !flags.n);
      LE:      condMet = flags.n || flags.z;
      OV:      condMet = flags.v;
      default: condMet = 1'b1; // UNC
    endcase
  end

  assign isBranch = branch.branch;
  assign taken    = branch.branch && condMet;

  // Target, fall through for anything but B and BR
  always_comb begin
    if (opcode == BR) begin
      target = rsData;                // Register indirect
    end else if (opcode == B) begin
      target = pcNext + branchOffset; // PC relative
    end else begin
      target = pcNext;
    end
  end

endmodule

`default_nettype wire

//--- hdl/operandSelect.sv
`timescale 1ns/100ps
`default_nettype none

module operandSelect import cpuPkg::*; (
  input  logic [wordWidth-1:0] inst, // Instruction word
  decodeCtrlIf.sink            ctrl, // Decoded control lines
  regReadIf.requester          rd,   // Register read ports
  output exBundle_t            ex,   // To execute
  output memBundle_t           mem,  // To memory
  output wbBundle_t            wb    // To write-back
);

  logic [regIdWidth-1:0] regRd;     // inst[11:8]
  logic [regIdWidth-1:0] regRs;     // inst[7:4]
  logic [regIdWidth-1:0] regRt;     // inst[3:0]
  logic [wordWidth-1:0]  memOffset; // Sign-extended LW/SW offset
  logic [wordWidth-1:0]  immValue;  // Zero-extended ALU immediate
  logic [wordWidth-1:0]  aluIn2;

  ////////////////////////////////////////////////////////////
  // Register addresses
  ////////////////////////////////////////////////////////////
  assign regRd = inst[11:8];
  assign regRs = inst[7:4];
  assign regRt = inst[3:0];

  assign rd.srcReg1 = ctrl.regSrc ? regRd : regRs;   // LLB/LHB modify rd in place
  assign rd.srcReg2 = ctrl.memWrite ? regRd : regRt; // SW stores rd

  ////////////////////////////////////////////////////////////
  // Second ALU operand
  ////////////////////////////////////////////////////////////
  assign memOffset = {{(wordWidth-4){inst[3]}}, inst[3:0]};
  // Byte immediate for LLB/LHB, else shift amount
  assign immValue = ctrl.regSrc ? {{(wordWidth-8){1'b0}}, inst[7:0]}
                                : {{(wordWidth-4){1'b0}}, inst[3:0]};

  always_comb begin
    if (ctrl.memEnable) begin
      aluIn2 = memOffset;   // Address = base + offset
    end else if (ctrl.aluSrc) begin
      aluIn2 = immValue;
    end else begin
      aluIn2 = rd.srcData2; // Register-register form
    end
  end

  // Pack the bundles
  assign ex  = '{aluIn1: rd.srcData1, aluIn2: aluIn2, aluOp: ctrl.aluOp,
                 zEn: ctrl.zEn, nvEn: ctrl.nvEn};
  assign mem = '{memWriteData: rd.srcData2, memEnable: ctrl.memEnable,
                 memWrite: ctrl.memWrite};
  assign wb  = '{regRd: regRd, regWrite: ctrl.regWrite, memToReg: ctrl.memToReg,
                 hlt: ctrl.hlt, pcs: ctrl.pcs};

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  reset,      // Synchronous clear
  regReadIf.responder           rd,         // Two read ports
  input  logic [regIdWidth-1:0] wbRegRd,    // Write address from write-back
  input  logic                  wbRegWrite, // Write strobe
  input  logic [wordWidth-1:0]  wbData      // Write data
);

  localparam int numRegs = 2**regIdWidth;

  logic [wordWidth-1:0] regs [numRegs]; // Entry 0 never written

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbRegWrite && (wbRegRd != '0)) begin // R0 ignores writes
      regs[wbRegRd] <= wbData;
    end
  end

  // One read port, zero register first, then same-cycle bypass
  function automatic logic [wordWidth-1:0] readPort(input logic [regIdWidth-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (wbRegWrite && (addr == wbRegRd)) begin
      return wbData; // Write in flight wins
    end
    return regs[addr];
  endfunction

  always_comb begin
    rd.srcData1 = readPort(rd.srcReg1);
    rd.srcData2 = readPort(rd.srcReg2);
  end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit import cpuPkg::*; (
  input opcode_t      opcode, // inst[15:12]
  decodeCtrlIf.source ctrl    // Decoded control lines
);

  ////////////////////////////////////////////////////////////
  // Opcode table
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Everything off unless the opcode says otherwise
    ctrl.aluSrc    = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.regSrc    = 1'b0;
    ctrl.memEnable = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.hlt       = 1'b0;
    ctrl.pcs       = 1'b0;
    ctrl.aluOp     = ADD;  // Address add for memory, don't care elsewhere
    ctrl.zEn       = 1'b0;
    ctrl.nvEn      = 1'b0;
    case (opcode)
      ADD, SUB: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1; // Only arithmetic sets N and V
      end
      XOR: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
      end
      RED, PADDSB: begin       // No flag update
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
      end
      SLL, SRA, ROR: begin     // 4-bit shift amount
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
      end
      LW: begin
        ctrl.regWrite  = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.memEnable = 1'b1;
      end
      SW: begin
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1; // Also steers rd onto read port 2
      end
      LLB, LHB: begin          // rd read, byte immediate merged in
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1;
        ctrl.aluOp    = opcode;
      end
      B, BR: ctrl.branch = 1'b1;
      PCS: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcs      = 1'b1;
      end
      HLT: ctrl.hlt = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/regReadIf.sv
`timescale 1ns/100ps
`default_nettype none

// Two read ports of the register file
interface regReadIf import cpuPkg::*; ();
  logic [regIdWidth-1:0] srcReg1;  // Port 1 address
  logic [regIdWidth-1:0] srcReg2;  // Port 2 address
  logic [wordWidth-1:0]  srcData1; // Port 1 data
  logic [wordWidth-1:0]  srcData2; // Port 2 data

  // Operand selector picks the addresses
  modport requester (output srcReg1, srcReg2, input srcData1, srcData2);
  // Register file answers
  modport responder (input srcReg1, srcReg2, output srcData1, srcData2);
endinterface

`default_nettype wire

//--- hdl/decodeCtrlIf.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded control lines, one level per signal
interface decodeCtrlIf import cpuPkg::*; ();
  logic    aluSrc;    // Immediate as second operand
  logic    memToReg;  // Load result goes to rd
  logic    regWrite;  // rd gets written
  logic    regSrc;    // rd read as first source (LLB/LHB)
  logic    memEnable; // Memory access
  logic    memWrite;  // Store
  logic    branch;    // B or BR
  logic    hlt;
  logic    pcs;
  opcode_t aluOp;     // ALU function
  logic    zEn;       // Z flag update
  logic    nvEn;      // N and V flag update

  modport source (output aluSrc, memToReg, regWrite, regSrc, memEnable, memWrite,
                  branch, hlt, pcs, aluOp, zEn, nvEn);
  modport sink (input aluSrc, memToReg, regWrite, regSrc, memEnable, memWrite,
                hlt, pcs, aluOp, zEn, nvEn);
  // Branch resolver needs only the branch line
  modport branchSink (input branch);
endinterface

`default_nettype wire

//--- hdl/cpuPkg.sv
package cpuPkg;

  ////////////////////////////////////////////////////////////
  // Machine widths
  ////////////////////////////////////////////////////////////
  parameter int wordWidth  = 16; // Data and address width
  parameter int regIdWidth = 4;  // Register id width, sixteen registers

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////
  // Opcode in inst[15:12]
  typedef enum logic [3:0] {
    ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB,
    LW, SW, LLB, LHB, B, BR, PCS, HLT
  } opcode_t;

  // Branch condition in inst[11:9]
  typedef enum logic [2:0] {
    NE,  // Z clear
    EQ,  // Z set
    GT,  // Z and N both clear
    LT,  // N set
    GE,  // Z set, or Z and N clear
    LE,  // N or Z set
    OV,  // V set
    UNC  // Always
  } cond_t;

  // Flag register from execute
  typedef struct packed {
    logic z; // Zero
    logic v; // Overflow
    logic n; // Negative
  } flags_t;

  ////////////////////////////////////////////////////////////
  // Pipeline bundles leaving decode
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [wordWidth-1:0] aluIn1; // First ALU operand
    logic [wordWidth-1:0] aluIn2; // Second ALU operand
    opcode_t              aluOp;  // ALU function
    logic                 zEn;    // Update Z
    logic                 nvEn;   // Update N and V
  } exBundle_t;                   // 38 bits

  typedef struct packed {
    logic [wordWidth-1:0] memWriteData; // Store data for SW
    logic                 memEnable;    // LW or SW
    logic                 memWrite;     // SW only
  } memBundle_t;                        // 18 bits

  typedef struct packed {
    logic [regIdWidth-1:0] regRd;    // Destination register
    logic                  regWrite; // Write back enable
    logic                  memToReg; // Write back from memory
    logic                  hlt;      // Halt
    logic                  pcs;      // Write back PC
  } wbBundle_t;                      // 8 bits

endpackage
